// ==== source/pert_pkg.sv ====
// Perturbation unit shared definitions

package pert_pkg;

  //////////////////////////////////////////////////
  // Modes
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    STALL_OFF    = 2'd0,
    STALL_FIXED  = 2'd1,
    STALL_RANDOM = 2'd2
  } stall_mode_e;

  typedef enum logic [1:0] {
    IRQ_PASS   = 2'd0,
    IRQ_RANDOM = 2'd1,
    IRQ_PC     = 2'd2
  } irq_mode_e;

  //////////////////////////////////////////////////
  // Bus types
  //////////////////////////////////////////////////

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [14:0] addr;
    logic [31:0] wdata;
  } dbg_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } dbg_rsp_t;

  //////////////////////////////////////////////////
  // Configuration
  //////////////////////////////////////////////////

  typedef struct packed {
    stall_mode_e mode;
    logic [7:0]  max_stall;
    logic [7:0]  gnt_stall;
    logic [7:0]  valid_stall;
  } stall_cfg_t;

  typedef struct packed {
    irq_mode_e   mode;
    logic [15:0] min_cycles;
    logic [15:0] max_cycles;
    logic [4:0]  min_id;
    logic [4:0]  max_id;
    logic [31:0] pc_trig;
  } irq_cfg_t;

  // Debug address bits 13:8 select the register window
  localparam logic [5:0] PERT_WINDOW = 6'd6;

  // Register indices, address bits 5:2
  localparam int unsigned REG_DATA_MODE   = 0;
  localparam int unsigned REG_DATA_MAX    = 1;
  localparam int unsigned REG_DATA_GNT    = 2;
  localparam int unsigned REG_DATA_VALID  = 3;
  localparam int unsigned REG_INSTR_MODE  = 4;
  localparam int unsigned REG_INSTR_MAX   = 5;
  localparam int unsigned REG_INSTR_GNT   = 6;
  localparam int unsigned REG_INSTR_VALID = 7;
  localparam int unsigned REG_IRQ_MODE    = 8;
  localparam int unsigned REG_IRQ_MIN_CYC = 9;
  localparam int unsigned REG_IRQ_MAX_CYC = 10;
  localparam int unsigned REG_IRQ_MIN_ID  = 11;
  localparam int unsigned REG_IRQ_MAX_ID  = 12;
  localparam int unsigned REG_IRQ_RESP_ID = 13;
  localparam int unsigned REG_IRQ_PC_TRIG = 14;

endpackage

// ==== source/pert_regfile.sv ====
// Perturbation register file
`timescale 1ns/10ps

module pert_regfile import pert_pkg::*; #(
  parameter int unsigned NUM_PERT_REGS = 15
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  dbg_req_t   dbg_req_i,
  output dbg_rsp_t   dbg_rsp_o,
  output dbg_req_t   dbg_fwd_req_o,
  input  dbg_rsp_t   dbg_fwd_rsp_i,
  input  logic       resp_we_i,
  input  logic [4:0] resp_id_i,
  output stall_cfg_t instr_cfg_o,
  output stall_cfg_t data_cfg_o,
  output irq_cfg_t   irq_cfg_o
);

  logic [31:0] regs_q [NUM_PERT_REGS];
  logic [3:0]  reg_idx;
  logic        win_hit;
  logic        idx_ok;
  logic        fwd_req_d;
  logic        fwd_gnt;
  logic        fwd_req_q;
  logic        fwd_we_q;
  logic [14:0] fwd_addr_q;
  logic [31:0] fwd_wdata_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;

  function automatic stall_cfg_t pack_stall(input logic [31:0] mode_w,
                                            input logic [31:0] max_w,
                                            input logic [31:0] gnt_w,
                                            input logic [31:0] valid_w);
    stall_cfg_t cfg;
    cfg.mode        = stall_mode_e'(mode_w[1:0]);
    cfg.max_stall   = max_w[7:0];
    cfg.gnt_stall   = gnt_w[7:0];
    cfg.valid_stall = valid_w[7:0];
    return cfg;
  endfunction

  assign reg_idx = dbg_req_i.addr[5:2];
  assign win_hit = dbg_req_i.req && (dbg_req_i.addr[13:8] == PERT_WINDOW);
  assign idx_ok  = 32'(reg_idx) < NUM_PERT_REGS;

  // Forwarded request drops once granted, the core lowers its own one cycle later
  assign fwd_gnt   = fwd_req_q & dbg_fwd_rsp_i.gnt;
  assign fwd_req_d = dbg_req_i.req & ~win_hit & ~fwd_gnt;

  //////////////////////////////////////////////////
  // Debug bus response
  //////////////////////////////////////////////////

  assign dbg_rsp_o.gnt    = win_hit | (dbg_req_i.req & fwd_gnt);
  assign dbg_rsp_o.rvalid = rvalid_q;
  assign dbg_rsp_o.rdata  = rdata_q;

  assign dbg_fwd_req_o.req   = fwd_req_q;
  assign dbg_fwd_req_o.we    = fwd_we_q;
  assign dbg_fwd_req_o.addr  = fwd_addr_q;
  assign dbg_fwd_req_o.wdata = fwd_wdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fwd_req_q <= 1'b0;
      fwd_we_q  <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      fwd_req_q <= fwd_req_d;
      fwd_we_q  <= fwd_req_d & dbg_req_i.we;
      rvalid_q  <= win_hit | dbg_fwd_rsp_i.rvalid;
    end
  end

  always_ff @(posedge clk_i) begin
    fwd_addr_q  <= dbg_req_i.addr;
    fwd_wdata_q <= dbg_req_i.wdata;
    if (win_hit) begin
      rdata_q <= idx_ok ? regs_q[reg_idx] : '0;
    end else begin
      rdata_q <= dbg_fwd_rsp_i.rdata;
    end
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_PERT_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      if (win_hit && dbg_req_i.we && idx_ok && (32'(reg_idx) != REG_IRQ_RESP_ID)) begin
        regs_q[reg_idx] <= dbg_req_i.wdata;
      end
      // Response id comes only from the core
      if (resp_we_i) begin
        regs_q[REG_IRQ_RESP_ID] <= 32'(resp_id_i);
      end
    end
  end

  assign data_cfg_o  = pack_stall(regs_q[REG_DATA_MODE], regs_q[REG_DATA_MAX],
                                  regs_q[REG_DATA_GNT], regs_q[REG_DATA_VALID]);
  assign instr_cfg_o = pack_stall(regs_q[REG_INSTR_MODE], regs_q[REG_INSTR_MAX],
                                  regs_q[REG_INSTR_GNT], regs_q[REG_INSTR_VALID]);

  assign irq_cfg_o.mode       = irq_mode_e'(regs_q[REG_IRQ_MODE][1:0]);
  assign irq_cfg_o.min_cycles = regs_q[REG_IRQ_MIN_CYC][15:0];
  assign irq_cfg_o.max_cycles = regs_q[REG_IRQ_MAX_CYC][15:0];
  assign irq_cfg_o.min_id     = regs_q[REG_IRQ_MIN_ID][4:0];
  assign irq_cfg_o.max_id     = regs_q[REG_IRQ_MAX_ID][4:0];
  assign irq_cfg_o.pc_trig    = regs_q[REG_IRQ_PC_TRIG];

  // Window writes never meet an open forwarded request
  a_win_no_fwd : assert property (@(posedge clk_i) disable iff (!rst_ni)
    win_hit && dbg_req_i.we |-> !dbg_fwd_req_o.req);

endmodule

// ==== source/pert_stall_gen.sv ====
// Memory handshake stall generator
`timescale 1ns/10ps

module pert_stall_gen import pert_pkg::*; #(
  parameter logic [15:0] LFSR_SEED = 16'hACE1
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  stall_cfg_t cfg_i,
  input  mem_req_t   core_req_i,
  output mem_rsp_t   core_rsp_o,
  output mem_req_t   mem_req_o,
  input  mem_rsp_t   mem_rsp_i
);

  typedef enum logic [1:0] {IDLE, GNT_WAIT, RSP_WAIT, RSP_HOLD} state_e;

  state_e      state_q, state_d;
  logic [7:0]  cnt_q, cnt_d;
  logic [15:0] lfsr_q;
  logic        lfsr_fb;
  logic [31:0] rdata_q;
  logic [8:0]  rand_span;
  logic [7:0]  gnt_delay;
  logic [7:0]  valid_delay;
  logic        stall_on;
  logic        fwd;

  assign stall_on = (cfg_i.mode == STALL_FIXED) || (cfg_i.mode == STALL_RANDOM);

  // Random delays from two LFSR bytes, limited to max_stall
  assign rand_span   = 9'(cfg_i.max_stall) + 9'd1;
  assign gnt_delay   = (cfg_i.mode == STALL_RANDOM) ?
                       8'(9'(lfsr_q[7:0]) % rand_span) : cfg_i.gnt_stall;
  assign valid_delay = (cfg_i.mode == STALL_RANDOM) ?
                       8'(9'(lfsr_q[15:8]) % rand_span) : cfg_i.valid_stall;

  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  //////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    fwd        = 1'b0;
    mem_req_o  = core_req_i;
    core_rsp_o = mem_rsp_i;
    if (stall_on) begin
      core_rsp_o.rvalid = 1'b0;
      core_rsp_o.rdata  = rdata_q;
      unique case (state_q)
        IDLE: begin
          if (core_req_i.req) begin
            if (gnt_delay == 8'd0) begin
              fwd     = 1'b1;
              state_d = mem_rsp_i.gnt ? RSP_WAIT : GNT_WAIT;
              cnt_d   = 8'd0;
            end else begin
              state_d = GNT_WAIT;
              cnt_d   = gnt_delay - 8'd1;
            end
          end
        end
        GNT_WAIT: begin
          if (cnt_q == 8'd0) begin
            fwd = 1'b1;
            if (mem_rsp_i.gnt) begin
              state_d = RSP_WAIT;
            end
          end else begin
            cnt_d = cnt_q - 8'd1;
          end
        end
        RSP_WAIT: begin
          if (mem_rsp_i.rvalid) begin
            if (valid_delay == 8'd0) begin
              core_rsp_o.rvalid = 1'b1;
              core_rsp_o.rdata  = mem_rsp_i.rdata;
              state_d           = IDLE;
            end else begin
              cnt_d   = valid_delay - 8'd1;
              state_d = RSP_HOLD;
            end
          end
        end
        RSP_HOLD: begin
          if (cnt_q == 8'd0) begin
            core_rsp_o.rvalid = 1'b1;
            state_d           = IDLE;
          end else begin
            cnt_d = cnt_q - 8'd1;
          end
        end
      endcase
      mem_req_o.req  = core_req_i.req & fwd;
      core_rsp_o.gnt = mem_rsp_i.gnt & fwd;
    end else begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      lfsr_q  <= LFSR_SEED;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      lfsr_q  <= {lfsr_q[14:0], lfsr_fb};
    end
  end

  // Held read data
  always_ff @(posedge clk_i) begin
    if ((state_q == RSP_WAIT) && mem_rsp_i.rvalid) begin
      rdata_q <= mem_rsp_i.rdata;
    end
  end

  // One delayed core response per transaction
  a_rvalid_once : assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_rsp_o.rvalid && stall_on |=> !(core_rsp_o.rvalid && stall_on));

  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.req && !mem_rsp_i.gnt |=> mem_req_o.req && $stable(mem_req_o.addr));

endmodule

// ==== source/pert_irq_gen.sv ====
// Interrupt injector
`timescale 1ns/10ps

module pert_irq_gen import pert_pkg::*; #(
  parameter logic [15:0] LFSR_SEED = 16'h1D87
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  irq_cfg_t    cfg_i,
  input  logic        irq_i,
  input  logic [4:0]  irq_id_i,
  input  logic        irq_ack_i,
  input  logic [31:0] pc_i,
  output logic        irq_o,
  output logic [4:0]  irq_id_o,
  output logic        irq_ack_o,
  output logic        resp_we_o
);

  logic [15:0] lfsr_q;
  logic        lfsr_fb;
  logic [15:0] cnt_q;
  logic        irq_q;
  logic [4:0]  id_q;
  logic        ack_q;
  logic [16:0] cyc_span;
  logic [15:0] cyc_load;
  logic [15:0] cnt_load;
  logic [5:0]  id_span;
  logic [4:0]  rand_id;
  logic        pc_hit;

  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  //////////////////////////////////////////////////
  // Random interval and id
  //////////////////////////////////////////////////

  assign cyc_span = (cfg_i.max_cycles >= cfg_i.min_cycles) ?
                    17'(cfg_i.max_cycles - cfg_i.min_cycles) + 17'd1 : 17'd1;
  assign cyc_load = 16'(17'(cfg_i.min_cycles) + (17'(lfsr_q) % cyc_span));
  // Load is one short since the counter starts a cycle after the ack
  assign cnt_load = (cyc_load == 16'd0) ? 16'd0 : cyc_load - 16'd1;

  assign id_span = (cfg_i.max_id >= cfg_i.min_id) ?
                   6'(cfg_i.max_id - cfg_i.min_id) + 6'd1 : 6'd1;
  assign rand_id = cfg_i.min_id + 5'(9'(lfsr_q[15:8]) % 9'(id_span));

  assign pc_hit = (pc_i == cfg_i.pc_trig);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= LFSR_SEED;
      cnt_q  <= '0;
      irq_q  <= 1'b0;
      ack_q  <= 1'b0;
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_fb};
      ack_q  <= irq_ack_i;
      case (cfg_i.mode)
        IRQ_RANDOM: begin
          if (irq_q) begin
            if (irq_ack_i) begin
              irq_q <= 1'b0;
              cnt_q <= cnt_load;
            end
          end else if (cnt_q <= 16'd1) begin
            irq_q <= 1'b1;
          end else begin
            cnt_q <= cnt_q - 16'd1;
          end
        end
        IRQ_PC: begin
          if (irq_q && irq_ack_i) begin
            irq_q <= 1'b0;
          end else if (pc_hit) begin
            irq_q <= 1'b1;
          end
        end
        default: begin
          // Pass-through, keep the interval armed
          irq_q <= 1'b0;
          cnt_q <= cnt_load;
        end
      endcase
    end
  end

  // Id frozen while an interrupt is pending
  always_ff @(posedge clk_i) begin
    if (!irq_q) begin
      id_q <= (cfg_i.mode == IRQ_PC) ? cfg_i.min_id : rand_id;
    end
  end

  assign irq_o     = (cfg_i.mode == IRQ_PASS) ? irq_i : irq_q;
  assign irq_id_o  = (cfg_i.mode == IRQ_PASS) ? irq_id_i : id_q;
  assign irq_ack_o = irq_ack_i;
  assign resp_we_o = irq_ack_i & ~ack_q;

  a_id_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cfg_i.mode == IRQ_RANDOM) && irq_o && (cfg_i.min_id <= cfg_i.max_id) |->
      (irq_id_o >= cfg_i.min_id) && (irq_id_o <= cfg_i.max_id));

endmodule

// ==== source/pert_unit.sv ====
// Perturbation unit top level
`timescale 1ns/10ps

module pert_unit import pert_pkg::*; #(
  parameter int unsigned NUM_PERT_REGS = 15,
  parameter logic [15:0] LFSR_SEED     = 16'hACE1
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  mem_req_t    core_instr_req_i,
  output mem_rsp_t    core_instr_rsp_o,
  input  mem_req_t    core_data_req_i,
  output mem_rsp_t    core_data_rsp_o,
  output mem_req_t    mem_instr_req_o,
  input  mem_rsp_t    mem_instr_rsp_i,
  output mem_req_t    mem_data_req_o,
  input  mem_rsp_t    mem_data_rsp_i,
  input  dbg_req_t    dbg_req_i,
  output dbg_rsp_t    dbg_rsp_o,
  output dbg_req_t    dbg_fwd_req_o,
  input  dbg_rsp_t    dbg_fwd_rsp_i,
  input  logic        irq_i,
  input  logic [4:0]  irq_id_i,
  output logic        irq_o,
  output logic [4:0]  irq_id_o,
  input  logic        irq_ack_i,
  output logic        irq_ack_o,
  input  logic [4:0]  core_resp_id_i,
  output logic [4:0]  core_resp_id_o,
  input  logic [31:0] pc_i
);

  stall_cfg_t instr_cfg;
  stall_cfg_t data_cfg;
  irq_cfg_t   irq_cfg;
  logic       resp_we;

  assign core_resp_id_o = core_resp_id_i;

  pert_regfile #(.NUM_PERT_REGS(NUM_PERT_REGS)) u_regfile (
    .clk_i, .rst_ni, .dbg_req_i, .dbg_rsp_o, .dbg_fwd_req_o, .dbg_fwd_rsp_i,
    .resp_we_i   (resp_we),
    .resp_id_i   (core_resp_id_i),
    .instr_cfg_o (instr_cfg),
    .data_cfg_o  (data_cfg),
    .irq_cfg_o   (irq_cfg)
  );

  //////////////////////////////////////////////////
  // Stall channels, each with its own seed
  //////////////////////////////////////////////////

  pert_stall_gen #(.LFSR_SEED(LFSR_SEED)) u_instr_stall (
    .clk_i, .rst_ni,
    .cfg_i      (instr_cfg),
    .core_req_i (core_instr_req_i),
    .core_rsp_o (core_instr_rsp_o),
    .mem_req_o  (mem_instr_req_o),
    .mem_rsp_i  (mem_instr_rsp_i)
  );

  pert_stall_gen #(.LFSR_SEED((LFSR_SEED ^ 16'h5A5A) | 16'h0001)) u_data_stall (
    .clk_i, .rst_ni,
    .cfg_i      (data_cfg),
    .core_req_i (core_data_req_i),
    .core_rsp_o (core_data_rsp_o),
    .mem_req_o  (mem_data_req_o),
    .mem_rsp_i  (mem_data_rsp_i)
  );

  pert_irq_gen #(.LFSR_SEED((LFSR_SEED ^ 16'hA3C4) | 16'h0001)) u_irq_gen (
    .clk_i, .rst_ni,
    .cfg_i     (irq_cfg),
    .irq_i, .irq_id_i, .irq_ack_i, .pc_i, .irq_o, .irq_id_o, .irq_ack_o,
    .resp_we_o (resp_we)
  );

endmodule

// ==== verif/tb_pert_unit.sv ====
// Perturbation unit testbench
`timescale 1ns/10ps

module tb_pert_unit import pert_pkg::*; ();

  logic        clk_i;
  logic        rst_ni;
  mem_req_t    core_req [2];
  mem_rsp_t    core_rsp [2];
  mem_req_t    mem_req [2];
  mem_rsp_t    mem_rsp [2];
  dbg_req_t    dbg_req;
  dbg_rsp_t    dbg_rsp;
  dbg_req_t    fwd_req;
  dbg_rsp_t    fwd_rsp;
  logic        irq_i;
  logic [4:0]  irq_id_i;
  logic        irq_o;
  logic [4:0]  irq_id_o;
  logic        irq_ack_i;
  logic        irq_ack_o;
  logic [4:0]  core_resp_id_i;
  logic [4:0]  core_resp_id_o;
  logic [31:0] pc_i;

  // Reference model state
  logic [31:0] regs_m [15];
  logic [31:0] mem_model [logic [31:0]];
  logic [4:0]  last_resp;
  int          req_cnt;
  int          rsp_cnt = 0;

  // Channel 0 is instruction, channel 1 is data
  pert_unit UUT (
    .clk_i, .rst_ni,
    .core_instr_req_i (core_req[0]),
    .core_instr_rsp_o (core_rsp[0]),
    .core_data_req_i  (core_req[1]),
    .core_data_rsp_o  (core_rsp[1]),
    .mem_instr_req_o  (mem_req[0]),
    .mem_instr_rsp_i  (mem_rsp[0]),
    .mem_data_req_o   (mem_req[1]),
    .mem_data_rsp_i   (mem_rsp[1]),
    .dbg_req_i        (dbg_req),
    .dbg_rsp_o        (dbg_rsp),
    .dbg_fwd_req_o    (fwd_req),
    .dbg_fwd_rsp_i    (fwd_rsp),
    .irq_i, .irq_id_i, .irq_o, .irq_id_o, .irq_ack_i, .irq_ack_o,
    .core_resp_id_i, .core_resp_id_o, .pc_i
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // Core responses seen on either channel
  always @(posedge clk_i) begin
    if (rst_ni) begin
      rsp_cnt += int'(core_rsp[0].rvalid) + int'(core_rsp[1].rvalid);
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic logic [14:0] win_addr(input int idx);
    logic [14:0] a;
    a      = '0;
    a[13:8] = PERT_WINDOW;
    a[5:2] = 4'(idx);
    return a;
  endfunction

  // Unwritten memory words derive from the whole address
  function automatic logic [31:0] mem_read(input logic [31:0] a);
    if (mem_model.exists(a)) begin
      return mem_model[a];
    end
    return {a[15:0], a[31:16]} ^ (a * 32'h9E37_79B9);
  endfunction

  task automatic dbg_win(input logic we, input int idx, input logic [31:0] wdata,
                         output logic [31:0] rdata);
    @(negedge clk_i);
    dbg_req = '{req: 1'b1, we: we, addr: win_addr(idx), wdata: wdata};
    #1;
    check_val("dbg_rsp_o.gnt", 32'(dbg_rsp.gnt), 32'd1);
    @(negedge clk_i);
    dbg_req.req = 1'b0;
    #1;
    check_val("dbg_rsp_o.rvalid", 32'(dbg_rsp.rvalid), 32'd1);
    check_val("dbg_fwd_req_o.req", 32'(fwd_req.req), 32'd0);
    rdata = dbg_rsp.rdata;
    if (we && idx != int'(REG_IRQ_RESP_ID)) begin
      regs_m[idx] = wdata;
    end
  endtask

  task automatic reg_write(input int idx, input logic [31:0] data);
    logic [31:0] unused;
    dbg_win(1'b1, idx, data, unused);
  endtask

  task automatic reg_read_check(input int idx, input logic [31:0] exp);
    logic [31:0] rd;
    dbg_win(1'b0, idx, 32'd0, rd);
    check_val($sformatf("reg[%0d]", idx), rd, exp);
  endtask

  // Debug access outside the window, answered by the debug unit model
  task automatic dbg_forward(input logic we, input logic [14:0] addr, input logic [31:0] wdata);
    logic [31:0] rsp_data;
    int          t;
    @(negedge clk_i);
    dbg_req = '{req: 1'b1, we: we, addr: addr, wdata: wdata};
    t = 0;
    #1;
    while (!fwd_req.req) begin
      @(negedge clk_i);
      #1;
      t++;
      if (t > 20) timeout_fail("forwarded debug request");
    end
    check_val("forward latency", 32'(t), 32'd1);
    check_val("dbg_fwd_req_o.we", 32'(fwd_req.we), 32'(we));
    check_val("dbg_fwd_req_o.addr", 32'(fwd_req.addr), 32'(addr));
    check_val("dbg_fwd_req_o.wdata", fwd_req.wdata, wdata);
    fwd_rsp.gnt = 1'b1;
    #1;
    check_val("dbg_rsp_o.gnt", 32'(dbg_rsp.gnt), 32'd1);
    @(negedge clk_i);
    dbg_req.req = 1'b0;
    rsp_data = $urandom();
    fwd_rsp = '{gnt: 1'b0, rvalid: 1'b1, rdata: rsp_data};
    #1;
    check_val("dbg_fwd_req_o.req", 32'(fwd_req.req), 32'd0);
    @(negedge clk_i);
    fwd_rsp.rvalid = 1'b0;
    #1;
    check_val("dbg_rsp_o.rvalid", 32'(dbg_rsp.rvalid), 32'd1);
    check_val("dbg_rsp_o.rdata", dbg_rsp.rdata, rsp_data);
  endtask

  task automatic set_stall(input int ch, input logic [1:0] mode, input int mx,
                           input int g, input int v);
    int base;
    base = (ch == 0) ? int'(REG_INSTR_MODE) : int'(REG_DATA_MODE);
    reg_write(base, 32'(mode));
    reg_write(base + 1, 32'(mx));
    reg_write(base + 2, 32'(g));
    reg_write(base + 3, 32'(v));
  endtask

  // One core transaction with the memory model answering
  task automatic mem_txn(input int ch, input logic we, input logic [31:0] addr,
                         input logic [31:0] wdata, output int g_dly, output int v_dly);
    logic [31:0] rd;
    logic [3:0]  be;
    int          gnt_wait;
    @(negedge clk_i);
    be = 4'($urandom());
    core_req[ch] = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    req_cnt++;
    g_dly = 0;
    #1;
    while (!mem_req[ch].req) begin
      @(negedge clk_i);
      #1;
      g_dly++;
      if (g_dly > 300) timeout_fail("memory request");
    end
    check_val("mem_req_o.we", 32'(mem_req[ch].we), 32'(we));
    check_val("mem_req_o.be", 32'(mem_req[ch].be), 32'(be));
    check_val("mem_req_o.addr", mem_req[ch].addr, addr);
    check_val("mem_req_o.wdata", mem_req[ch].wdata, wdata);
    gnt_wait = int'($urandom_range(2, 0));
    repeat (gnt_wait) @(negedge clk_i);
    mem_rsp[ch].gnt = 1'b1;
    #1;
    check_val("core_rsp_o.gnt", 32'(core_rsp[ch].gnt), 32'd1);
    @(negedge clk_i);
    core_req[ch].req = 1'b0;
    mem_rsp[ch].gnt  = 1'b0;
    rd = we ? 32'd0 : mem_read(addr);
    if (we) begin
      mem_model[addr] = wdata;
    end
    mem_rsp[ch].rvalid = 1'b1;
    mem_rsp[ch].rdata  = rd;
    v_dly = 0;
    #1;
    while (!core_rsp[ch].rvalid) begin
      @(negedge clk_i);
      mem_rsp[ch].rvalid = 1'b0;
      #1;
      v_dly++;
      if (v_dly > 300) timeout_fail("core read response");
    end
    check_val("core_rsp_o.rdata", core_rsp[ch].rdata, rd);
    @(negedge clk_i);
    mem_rsp[ch].rvalid = 1'b0;
  endtask

  function automatic logic [31:0] rand_addr();
    return 32'h0000_1000 | (32'($urandom_range(63, 0)) << 2);
  endfunction

  task automatic drive_ack();
    @(negedge clk_i);
    irq_ack_i      = 1'b1;
    last_resp      = 5'($urandom());
    core_resp_id_i = last_resp;
    #1;
    check_val("irq_ack_o", 32'(irq_ack_o), 32'd1);
    check_val("core_resp_id_o", 32'(core_resp_id_o), 32'(last_resp));
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    int          idx;
    int          g;
    int          v;
    int          mx;
    int          cyc;
    int          min_c;
    int          max_c;
    int          min_id;
    int          max_id;
    logic [31:0] data;
    logic [14:0] a;

    void'($urandom(32'h30b7_8361));
    rst_ni         = 1'b0;
    core_req[0]    = '0;
    core_req[1]    = '0;
    mem_rsp[0]     = '0;
    mem_rsp[1]     = '0;
    dbg_req        = '0;
    fwd_rsp        = '0;
    irq_i          = 1'b0;
    irq_id_i       = '0;
    irq_ack_i      = 1'b0;
    core_resp_id_i = '0;
    pc_i           = '0;
    last_resp      = '0;
    req_cnt        = 0;
    for (int i = 0; i < 15; i++) regs_m[i] = '0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    // Register window
    for (int n = 0; n < 40; n++) begin
      idx = int'($urandom_range(14, 0));
      if (idx == int'(REG_IRQ_RESP_ID)) begin
        reg_read_check(idx, 32'(last_resp));
      end else if ($urandom_range(1, 0) == 1) begin
        reg_write(idx, $urandom());
      end else begin
        reg_read_check(idx, regs_m[idx]);
      end
    end
    reg_write(int'(REG_IRQ_MODE), 32'(IRQ_PASS));

    // Forwarding of non-window accesses
    for (int n = 0; n < 10; n++) begin
      a = 15'($urandom());
      if (a[13:8] == PERT_WINDOW) a[13] = 1'b1;
      dbg_forward(1'($urandom()), a, $urandom());
    end

    // Fixed, random and off stalls on both channels
    for (int ch = 0; ch < 2; ch++) begin
      for (int n = 0; n < 6; n++) begin
        set_stall(ch, STALL_FIXED, 0, int'($urandom_range(5, 0)), int'($urandom_range(5, 0)));
        mem_txn(ch, 1'($urandom()), rand_addr(), $urandom(), g, v);
        check_val("gnt stall", 32'(g), regs_m[(ch == 0) ? 6 : 2]);
        check_val("rvalid stall", 32'(v), regs_m[(ch == 0) ? 7 : 3]);
      end
      mx = int'($urandom_range(6, 1));
      set_stall(ch, STALL_RANDOM, mx, 0, 0);
      for (int n = 0; n < 10; n++) begin
        mem_txn(ch, 1'($urandom()), rand_addr(), $urandom(), g, v);
        check_val("random gnt stall within max", 32'(g <= mx), 32'd1);
        check_val("random rvalid stall within max", 32'(v <= mx), 32'd1);
      end
      set_stall(ch, STALL_OFF, 0, 3, 3);
      for (int n = 0; n < 4; n++) begin
        mem_txn(ch, 1'($urandom()), rand_addr(), $urandom(), g, v);
        check_val("pass gnt delay", 32'(g), 32'd0);
        check_val("pass rvalid delay", 32'(v), 32'd0);
      end
    end
    check_val("request vs response count", 32'(req_cnt), 32'(rsp_cnt));

    // Interrupt pass-through
    for (int n = 0; n < 8; n++) begin
      @(negedge clk_i);
      irq_i    = 1'($urandom());
      irq_id_i = 5'($urandom());
      #1;
      check_val("irq_o", 32'(irq_o), 32'(irq_i));
      check_val("irq_id_o", 32'(irq_id_o), 32'(irq_id_i));
    end
    irq_i = 1'b0;

    // Random interval interrupts
    min_c  = int'($urandom_range(8, 3));
    max_c  = min_c + int'($urandom_range(12, 0));
    min_id = int'($urandom_range(20, 0));
    max_id = min_id + int'($urandom_range(10, 0));
    reg_write(int'(REG_IRQ_MIN_CYC), 32'(min_c));
    reg_write(int'(REG_IRQ_MAX_CYC), 32'(max_c));
    reg_write(int'(REG_IRQ_MIN_ID), 32'(min_id));
    reg_write(int'(REG_IRQ_MAX_ID), 32'(max_id));
    reg_write(int'(REG_IRQ_MODE), 32'(IRQ_RANDOM));
    cyc = 0;
    while (!irq_o) begin
      @(negedge clk_i);
      #1;
      cyc++;
      if (cyc > 2000) timeout_fail("first random interrupt");
    end
    for (int n = 0; n < 6; n++) begin
      drive_ack();
      @(negedge clk_i);
      irq_ack_i = 1'b0;
      cyc = 1;
      #1;
      check_val("irq_o after ack", 32'(irq_o), 32'd0);
      while (!irq_o) begin
        @(negedge clk_i);
        #1;
        cyc++;
        if (cyc > 200) timeout_fail("random interrupt");
      end
      check_val("irq interval within range", 32'(cyc >= min_c && cyc <= max_c), 32'd1);
      check_val("irq id within range",
                32'(int'(irq_id_o) >= min_id && int'(irq_id_o) <= max_id), 32'd1);
      reg_read_check(int'(REG_IRQ_RESP_ID), 32'(last_resp));
    end
    drive_ack();
    @(negedge clk_i);
    irq_ack_i = 1'b0;

    // PC triggered interrupts
    reg_write(int'(REG_IRQ_MODE), 32'(IRQ_PASS));
    for (int n = 0; n < 4; n++) begin
      data = $urandom() & 32'hFFFF_FFFC;
      pc_i = data ^ 32'h10;
      reg_write(int'(REG_IRQ_PC_TRIG), data);
      reg_write(int'(REG_IRQ_MODE), 32'(IRQ_PC));
      @(negedge clk_i);
      #1;
      check_val("irq_o before pc match", 32'(irq_o), 32'd0);
      @(negedge clk_i);
      pc_i = data;
      #1;
      check_val("irq_o at pc match", 32'(irq_o), 32'd0);
      @(negedge clk_i);
      pc_i = data ^ 32'h4;
      #1;
      check_val("irq_o after pc match", 32'(irq_o), 32'd1);
      drive_ack();
      @(negedge clk_i);
      irq_ack_i = 1'b0;
      #1;
      check_val("irq_o after ack", 32'(irq_o), 32'd0);
      reg_read_check(int'(REG_IRQ_RESP_ID), 32'(last_resp));
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== verilog.f ====
source/pert_pkg.sv
source/pert_regfile.sv
source/pert_stall_gen.sv
source/pert_irq_gen.sv
source/pert_unit.sv
verif/tb_pert_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_pert_unit
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
